//--- fb_writer_patterns.txt
# x y pixel in hex, resp_delay in decimal cycles (255 = slave never answers), bresp in hex
# bresp 0 is OKAY, 2 is SLVERR, 3 is DECERR
000 001 abc 0 0
000 000 fff 1 0
07f 07f 123 2 0
080 000 456 0 0
000 080 789 0 0
005 003 0f0 3 2
010 020 00f 0 3
020 010 f00 255 0
021 010 f01 0 0
fff fff 555 0 0
07f 000 a5a 4 0
000 07f 5a5 1 0
040 040 111 0 2
041 040 222 2 0
0c8 001 333 0 0
001 0c8 444 1 0
063 02a 777 255 0
064 02a 888 5 0
12c 07f 999 0 0
07e 07e eee 0 0
033 044 0a0 6 0
034 044 0b0 0 0

//--- files.f
fb_pkg.sv
fb_pixel_stage.sv
fb_resp_timer.sv
fb_write_fsm.sv
fb_writer_top.sv
fb_writer_checker.sv
fb_writer_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module fb_writer_tb -f files.f -o sim_fb_writer
./obj_dir/sim_fb_writer > sim.log 2>&1
cat sim.log
if grep -q "Test completed successfully" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

//--- fb_writer_tb.sv
module fb_writer_tb;

  localparam int resp_timeout = 16;
  localparam int max_tests    = 64;
  localparam int no_resp      = 255;  // slave stays silent and the timer has to step in
  localparam int vis_size     = 128;  // visible width and height of the test screen
  localparam int axi_id       = 0;

  localparam logic [1:0] kind_written = 2'd0;
  localparam logic [1:0] kind_failed  = 2'd1;
  localparam logic [1:0] kind_clipped = 2'd2;

  logic                                clk;
  logic                                rst_n;
  logic [fb_pkg::h_width-1:0]          h_visible;
  logic [fb_pkg::v_width-1:0]          v_visible;
  logic                                s_gfx_valid;
  fb_pkg::fb_pixel_t                   s_gfx;
  logic                                s_gfx_ready;
  logic                                m_axi_awvalid;
  logic [fb_pkg::axi_id_width-1:0]     m_axi_awid;
  logic [fb_pkg::axi_addr_width-1:0]   m_axi_awaddr;
  logic [7:0]                          m_axi_awlen;
  logic [2:0]                          m_axi_awsize;
  logic [1:0]                          m_axi_awburst;
  logic                                m_axi_awready;
  logic                                m_axi_wvalid;
  logic [fb_pkg::axi_data_width-1:0]   m_axi_wdata;
  logic [fb_pkg::axi_data_width/8-1:0] m_axi_wstrb;
  logic                                m_axi_wlast;
  logic                                m_axi_wready;
  logic                                m_axi_bvalid;
  logic [fb_pkg::axi_id_width-1:0]     m_axi_bid;
  logic [1:0]                          m_axi_bresp;
  logic                                m_axi_bready;
  fb_pkg::fb_status_t                  status;

  logic                                exp_push;
  logic [1:0]                          exp_kind;
  logic [fb_pkg::axi_addr_width-1:0]   exp_addr;
  logic [fb_pkg::axi_data_width-1:0]   exp_data;
  logic                                report_req;
  int                                  tests_done;
  int                                  pass_count;
  int                                  fail_count;

  logic [11:0] t_x     [max_tests];
  logic [11:0] t_y     [max_tests];
  logic [11:0] t_pix   [max_tests];
  int          t_delay [max_tests];
  logic [1:0]  t_bresp [max_tests];
  int          n_tests     = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;

  fb_writer_top #(.RESP_TIMEOUT(resp_timeout), .AXI_ID(axi_id)) fb_writer_top_i (.*);

  fb_writer_checker #(
    .AXI_ID(axi_id)
  ) fb_writer_checker_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .exp_push  (exp_push),
    .exp_kind  (exp_kind),
    .exp_addr  (exp_addr),
    .exp_data  (exp_data),
    .report_req(report_req),
    .awvalid   (m_axi_awvalid),
    .awready   (m_axi_awready),
    .awid      (m_axi_awid),
    .awaddr    (m_axi_awaddr),
    .awlen     (m_axi_awlen),
    .awsize    (m_axi_awsize),
    .awburst   (m_axi_awburst),
    .wvalid    (m_axi_wvalid),
    .wready    (m_axi_wready),
    .wdata     (m_axi_wdata),
    .wstrb     (m_axi_wstrb),
    .wlast     (m_axi_wlast),
    .status    (status),
    .tests_done(tests_done),
    .pass_count(pass_count),
    .fail_count(fail_count)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // the slave accepts address and data on random cycles
  always @(posedge clk) begin
    #1;
    m_axi_awready = 1'($urandom);
    m_axi_wready  = 1'($urandom);
  end

  task automatic load_patterns();
    int          fd;
    int          fields;
    string       line;
    logic [11:0] x;
    logic [11:0] y;
    logic [11:0] pix;
    int          delay;
    logic [1:0]  resp;
    fd = $fopen("fb_writer_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open the pattern file fb_writer_patterns.txt");
    end else begin
      while (!$feof(fd) && n_tests < max_tests) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line.getc(0) != "#") begin
          fields = $sscanf(line, "%h %h %h %d %h", x, y, pix, delay, resp);
          if (fields == 5) begin
            t_x[n_tests]     = x;
            t_y[n_tests]     = y;
            t_pix[n_tests]   = pix;
            t_delay[n_tests] = delay;
            t_bresp[n_tests] = resp;
            n_tests++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_test(input int i);
    logic accepted;
    logic hs;
    logic kept;
    kept = (int'(t_x[i]) < vis_size) && (int'(t_y[i]) < vis_size);
    @(posedge clk);
    #1;
    exp_push = 1'b1;
    if (!kept) exp_kind = kind_clipped;
    else if (t_delay[i] == no_resp || t_bresp[i] != fb_pkg::axi_resp_okay) exp_kind = kind_failed;
    else exp_kind = kind_written;
    exp_addr    = 20'(int'(t_y[i]) * vis_size + int'(t_x[i]));  // row major pixel index
    exp_data    = {4'h0, t_pix[i]};
    s_gfx_valid = 1'b1;
    s_gfx       = '{x: t_x[i], y: t_y[i], pixel: t_pix[i]};
    @(posedge clk);
    accepted = s_gfx_ready;
    #1;
    exp_push = 1'b0;
    while (!accepted) begin
      @(posedge clk);
      accepted = s_gfx_ready;
      #1;
    end
    s_gfx_valid = 1'b0;
    if (kept && t_delay[i] != no_resp) begin
      while (!m_axi_bready) begin
        @(posedge clk);
        #1;
      end
      repeat (t_delay[i]) begin
        @(posedge clk);
        #1;
      end
      m_axi_bvalid = 1'b1;
      m_axi_bresp  = t_bresp[i];
      hs = 1'b0;
      while (!hs) begin
        @(posedge clk);
        hs = m_axi_bready;
        #1;
      end
      m_axi_bvalid = 1'b0;
    end
    while (tests_done <= i) begin
      @(posedge clk);
      #1;
    end
  endtask

  initial begin
    wait (cycle_limit > 0);
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("simulation timed out after %0d cycles", cycle_count);
    $display("Test failed");
    $finish;
  end

  initial begin
    rst_n         = 1'b0;
    h_visible     = 12'(vis_size);
    v_visible     = 12'(vis_size);
    s_gfx_valid   = 1'b0;
    s_gfx         = '0;
    m_axi_awready = 1'b0;
    m_axi_wready  = 1'b0;
    m_axi_bvalid  = 1'b0;
    m_axi_bid     = fb_pkg::axi_id_width'(axi_id);
    m_axi_bresp   = '0;
    exp_push      = 1'b0;
    exp_kind      = '0;
    exp_addr      = '0;
    exp_data      = '0;
    report_req    = 1'b0;
    void'($urandom(32'h07fd_7862));
    load_patterns();
    cycle_limit = n_tests * (resp_timeout + 40);
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;
    for (int i = 0; i < n_tests; i++) run_test(i);
    report_req = 1'b1;
    @(posedge clk);
    #1;
    if (n_tests > 0 && fail_count == 0 && tests_done == n_tests && pass_count == n_tests + 1)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

//--- fb_writer_checker.sv
module fb_writer_checker #(
  parameter int AXI_ID = 0
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                exp_push,
  input  logic [1:0]                          exp_kind,
  input  logic [fb_pkg::axi_addr_width-1:0]   exp_addr,
  input  logic [fb_pkg::axi_data_width-1:0]   exp_data,
  input  logic                                report_req,
  input  logic                                awvalid,
  input  logic                                awready,
  input  logic [fb_pkg::axi_id_width-1:0]     awid,
  input  logic [fb_pkg::axi_addr_width-1:0]   awaddr,
  input  logic [7:0]                          awlen,
  input  logic [2:0]                          awsize,
  input  logic [1:0]                          awburst,
  input  logic                                wvalid,
  input  logic                                wready,
  input  logic [fb_pkg::axi_data_width-1:0]   wdata,
  input  logic [fb_pkg::axi_data_width/8-1:0] wstrb,
  input  logic                                wlast,
  input  fb_pkg::fb_status_t                  status,
  output int                                  tests_done,
  output int                                  pass_count,
  output int                                  fail_count
);

  localparam logic [1:0] kind_written = 2'd0;
  localparam logic [1:0] kind_failed  = 2'd1;

  // a 16 bit bus moves two bytes per beat, and a single beat is sent as INCR
  localparam logic [2:0] exp_awsize  = 3'd1;
  localparam logic [1:0] exp_awburst = 2'b01;
  localparam logic [fb_pkg::axi_id_width-1:0] exp_awid = fb_pkg::axi_id_width'(AXI_ID);

  typedef struct packed {
    logic [1:0]                        kind;
    logic [fb_pkg::axi_addr_width-1:0] addr;
    logic [fb_pkg::axi_data_width-1:0] data;
  } pending_t;

  pending_t           exp_q[$];
  pending_t           cur;
  fb_pkg::fb_status_t prev_status;
  fb_pkg::fb_status_t exp_status;
  logic               in_reset;
  logic               reported;
  logic               aw_seen;
  logic               w_seen;
  logic               test_bad;

  task note_error(input string msg);
    $display("** Error at time %0t: %s", $time, msg);
    test_bad = 1'b1;
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      exp_q.delete();
      prev_status = status;
      exp_status  = '0;
      in_reset    = 1'b1;
      reported    = 1'b0;
      aw_seen     = 1'b0;
      w_seen      = 1'b0;
      test_bad    = 1'b0;
      tests_done  = 0;
      pass_count  = 0;
      fail_count  = 0;
    end else begin
      if (in_reset) begin
        in_reset = 1'b0;
        if (awvalid !== 1'b0 || wvalid !== 1'b0 || status !== '0) begin
          $display("** Error at time %0t: outputs not idle after reset", $time);
          $display("reset check: FAIL");
          fail_count++;
        end else begin
          $display("reset check: pass");
          pass_count++;
        end
      end
      if (exp_push) exp_q.push_back({exp_kind, exp_addr, exp_data});
      if (awvalid && awready) begin
        if (exp_q.size() == 0 || exp_q[0].kind == 2'd2 || aw_seen) begin
          note_error("address handshake that no pending pixel accounts for");
        end else begin
          aw_seen = 1'b1;
          if (awaddr !== exp_q[0].addr)
            note_error($sformatf("awaddr %h, expected %h", awaddr, exp_q[0].addr));
          if (awlen !== 8'd0) note_error($sformatf("awlen %0d, expected 0", awlen));
          if (awid !== exp_awid || awsize !== exp_awsize || awburst !== exp_awburst)
            note_error($sformatf("awid/awsize/awburst %0d/%0d/%0d, expected %0d/%0d/%0d",
                                 awid, awsize, awburst, exp_awid, exp_awsize, exp_awburst));
        end
      end
      if (wvalid && wready) begin
        if (exp_q.size() == 0 || exp_q[0].kind == 2'd2 || w_seen) begin
          note_error("data handshake that no pending pixel accounts for");
        end else begin
          w_seen = 1'b1;
          if (wdata !== exp_q[0].data)
            note_error($sformatf("wdata %h, expected %h", wdata, exp_q[0].data));
          if (wstrb !== '1 || wlast !== 1'b1) note_error("wstrb or wlast not set");
        end
      end
      // every finished pixel moves exactly one status count
      if (status !== prev_status) begin
        if (exp_q.size() == 0) begin
          $display("** Error at time %0t: status changed with no pixel pending", $time);
          fail_count++;
        end else begin
          cur = exp_q.pop_front();
          if (cur.kind == kind_written) exp_status.writes_done = exp_status.writes_done + 16'd1;
          else if (cur.kind == kind_failed) exp_status.resp_errors = exp_status.resp_errors + 8'd1;
          else exp_status.clipped = exp_status.clipped + 16'd1;
          if (status !== exp_status)
            note_error($sformatf("status done/clipped/errors %0d/%0d/%0d, expected %0d/%0d/%0d",
                                 status.writes_done, status.clipped, status.resp_errors,
                                 exp_status.writes_done, exp_status.clipped,
                                 exp_status.resp_errors));
          if (cur.kind != 2'd2 && !(aw_seen && w_seen))
            note_error("write finished before both channels completed");
          tests_done++;
          if (test_bad) fail_count++;
          else pass_count++;
          $display("test %0d (kind %0d, addr %h): %s", tests_done, cur.kind, cur.addr,
                   test_bad ? "FAIL" : "pass");
          aw_seen  = 1'b0;
          w_seen   = 1'b0;
          test_bad = 1'b0;
        end
        prev_status = status;
      end
      if (report_req && !reported) begin
        reported = 1'b1;
        $display("checks passed %0d, failed %0d", pass_count, fail_count);
      end
    end
  end

endmodule

//--- fb_writer_top.sv
module fb_writer_top #(
  parameter int RESP_TIMEOUT = 64,
  parameter int AXI_ID       = 0
) (
  input  logic                                clk,
  input  logic                                rst_n,

  input  logic [fb_pkg::h_width-1:0]          h_visible,
  input  logic [fb_pkg::v_width-1:0]          v_visible,

  input  logic                                s_gfx_valid,
  input  fb_pkg::fb_pixel_t                   s_gfx,
  output logic                                s_gfx_ready,

  output logic                                m_axi_awvalid,
  output logic [fb_pkg::axi_id_width-1:0]     m_axi_awid,
  output logic [fb_pkg::axi_addr_width-1:0]   m_axi_awaddr,
  output logic [7:0]                          m_axi_awlen,
  output logic [2:0]                          m_axi_awsize,
  output logic [1:0]                          m_axi_awburst,
  input  logic                                m_axi_awready,

  output logic                                m_axi_wvalid,
  output logic [fb_pkg::axi_data_width-1:0]   m_axi_wdata,
  output logic [fb_pkg::axi_data_width/8-1:0] m_axi_wstrb,
  output logic                                m_axi_wlast,
  input  logic                                m_axi_wready,

  input  logic                                m_axi_bvalid,
  input  logic [fb_pkg::axi_id_width-1:0]     m_axi_bid,
  input  logic [1:0]                          m_axi_bresp,
  output logic                                m_axi_bready,

  output fb_pkg::fb_status_t                  status
);

  logic              wr_valid;
  logic              wr_ready;
  fb_pkg::fb_write_t wr;
  logic              timer_run;
  logic              timeout;
  logic [15:0]       clipped;
  logic [15:0]       writes_done;
  logic [7:0]        resp_errors;

  fb_pixel_stage fb_pixel_stage_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .h_visible  (h_visible),
    .v_visible  (v_visible),
    .s_gfx_valid(s_gfx_valid),
    .s_gfx      (s_gfx),
    .s_gfx_ready(s_gfx_ready),
    .wr_valid   (wr_valid),
    .wr         (wr),
    .wr_ready   (wr_ready),
    .clipped    (clipped)
  );

  fb_write_fsm #(
    .AXI_ID(AXI_ID)
  ) fb_write_fsm_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .wr_valid     (wr_valid),
    .wr           (wr),
    .wr_ready     (wr_ready),
    .m_axi_awvalid(m_axi_awvalid),
    .m_axi_awid   (m_axi_awid),
    .m_axi_awaddr (m_axi_awaddr),
    .m_axi_awlen  (m_axi_awlen),
    .m_axi_awsize (m_axi_awsize),
    .m_axi_awburst(m_axi_awburst),
    .m_axi_awready(m_axi_awready),
    .m_axi_wvalid (m_axi_wvalid),
    .m_axi_wdata  (m_axi_wdata),
    .m_axi_wstrb  (m_axi_wstrb),
    .m_axi_wlast  (m_axi_wlast),
    .m_axi_wready (m_axi_wready),
    .m_axi_bvalid (m_axi_bvalid),
    .m_axi_bid    (m_axi_bid),
    .m_axi_bresp  (m_axi_bresp),
    .m_axi_bready (m_axi_bready),
    .timer_run    (timer_run),
    .timeout      (timeout),
    .writes_done  (writes_done),
    .resp_errors  (resp_errors)
  );

  fb_resp_timer #(
    .RESP_TIMEOUT(RESP_TIMEOUT)
  ) fb_resp_timer_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .timer_run(timer_run),
    .timeout  (timeout)
  );

  always_comb begin
    status             = '0;
    status.writes_done = writes_done;
    status.clipped     = clipped;
    status.resp_errors = resp_errors;
  end

endmodule

//--- fb_write_fsm.sv
module fb_write_fsm #(
  parameter int AXI_ID = 0
) (
  input  logic                              clk,
  input  logic                              rst_n,

  input  logic                              wr_valid,
  input  fb_pkg::fb_write_t                 wr,
  output logic                              wr_ready,

  output logic                              m_axi_awvalid,
  output logic [fb_pkg::axi_id_width-1:0]   m_axi_awid,
  output logic [fb_pkg::axi_addr_width-1:0] m_axi_awaddr,
  output logic [7:0]                        m_axi_awlen,
  output logic [2:0]                        m_axi_awsize,
  output logic [1:0]                        m_axi_awburst,
  input  logic                              m_axi_awready,

  output logic                              m_axi_wvalid,
  output logic [fb_pkg::axi_data_width-1:0] m_axi_wdata,
  output logic [fb_pkg::axi_data_width/8-1:0] m_axi_wstrb,
  output logic                              m_axi_wlast,
  input  logic                              m_axi_wready,

  input  logic                              m_axi_bvalid,
  input  logic [fb_pkg::axi_id_width-1:0]   m_axi_bid,
  input  logic [1:0]                        m_axi_bresp,
  output logic                              m_axi_bready,

  output logic                              timer_run,
  input  logic                              timeout,

  output logic [15:0]                       writes_done,
  output logic [7:0]                        resp_errors
);

  localparam logic [fb_pkg::axi_id_width-1:0] axi_id = fb_pkg::axi_id_width'(AXI_ID);

  typedef enum logic [1:0] {
    IDLE,
    ADDR_DATA,
    RESP
  } state_t;

  state_t            state;
  fb_pkg::fb_write_t cur;  // write held for the length of the transaction
  logic              aw_done;
  logic              w_done;
  logic              aw_hs;
  logic              w_hs;
  logic              aw_finished;
  logic              w_finished;
  logic              resp_ok;

  assign wr_ready = (state == IDLE);

  assign m_axi_awvalid = (state == ADDR_DATA) && !aw_done;
  assign m_axi_wvalid  = (state == ADDR_DATA) && !w_done;
  assign m_axi_bready  = (state == RESP);
  assign timer_run     = (state == RESP);

  // single beat, full width, incrementing burst type
  assign m_axi_awid    = axi_id;
  assign m_axi_awaddr  = cur.addr;
  assign m_axi_awlen   = 8'd0;
  assign m_axi_awsize  = 3'($clog2(fb_pkg::axi_data_width / 8));
  assign m_axi_awburst = 2'b01;
  assign m_axi_wdata   = cur.data;
  assign m_axi_wstrb   = '1;
  assign m_axi_wlast   = 1'b1;

  assign aw_hs = m_axi_awvalid && m_axi_awready;
  assign w_hs  = m_axi_wvalid && m_axi_wready;

  // the two channels may finish in either order or together
  assign aw_finished = aw_done || aw_hs;
  assign w_finished  = w_done || w_hs;

  // a response for another ID is treated as a failed write
  assign resp_ok = (m_axi_bresp == fb_pkg::axi_resp_okay) && (m_axi_bid == axi_id);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= IDLE;
      aw_done     <= 1'b0;
      w_done      <= 1'b0;
      writes_done <= '0;
      resp_errors <= '0;
    end else begin
      case (state)
        IDLE: begin
          aw_done <= 1'b0;
          w_done  <= 1'b0;
          if (wr_valid) begin
            state <= ADDR_DATA;
          end
        end
        ADDR_DATA: begin
          if (aw_finished && w_finished) begin
            state   <= RESP;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
          end else begin
            aw_done <= aw_finished;
            w_done  <= w_finished;
          end
        end
        RESP: begin
          if (m_axi_bvalid) begin
            state <= IDLE;
            if (resp_ok) begin
              writes_done <= writes_done + 16'd1;
            end else begin
              resp_errors <= resp_errors + 8'd1;
            end
          end else if (timeout) begin
            state       <= IDLE;  // give up on a slave that never answers
            resp_errors <= resp_errors + 8'd1;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == IDLE && wr_valid) begin
      cur <= wr;
    end
  end

endmodule

//--- fb_resp_timer.sv
module fb_resp_timer #(
  parameter int RESP_TIMEOUT = 64
) (
  input  logic clk,
  input  logic rst_n,
  input  logic timer_run,
  output logic timeout
);

  localparam int cnt_width = $clog2(RESP_TIMEOUT + 1);
  localparam logic [cnt_width-1:0] cnt_limit = cnt_width'(RESP_TIMEOUT);

  logic [cnt_width-1:0] count;
  logic                 at_limit;

  assign at_limit = (count == cnt_limit);

  // the count sticks at the limit so a long stall cannot wrap back to zero
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
    end else if (!timer_run) begin
      count <= '0;  // every new wait starts from zero
    end else if (!at_limit) begin
      count <= count + 1'b1;
    end
  end

  assign timeout = timer_run && at_limit;

endmodule

//--- fb_pixel_stage.sv
module fb_pixel_stage (
  input  logic                        clk,
  input  logic                        rst_n,

  input  logic [fb_pkg::h_width-1:0]  h_visible,
  input  logic [fb_pkg::v_width-1:0]  v_visible,

  input  logic                        s_gfx_valid,
  input  fb_pkg::fb_pixel_t           s_gfx,
  output logic                        s_gfx_ready,

  output logic                        wr_valid,
  output fb_pkg::fb_write_t           wr,
  input  logic                        wr_ready,

  output logic [15:0]                 clipped
);

  logic                              accept;
  logic                              in_range;
  logic [fb_pkg::axi_addr_width-1:0] x_ext;
  logic [fb_pkg::axi_addr_width-1:0] y_ext;
  logic [fb_pkg::axi_addr_width-1:0] hv_ext;
  logic [fb_pkg::axi_addr_width-1:0] pix_index;
  fb_pkg::fb_write_t                 next_wr;

  // the output register can take a new item when empty or when it drains this cycle
  assign s_gfx_ready = !wr_valid || wr_ready;
  assign accept      = s_gfx_valid && s_gfx_ready;

  assign in_range = (s_gfx.x < h_visible) && (s_gfx.y < v_visible);

  // widen before the multiply so the product is not cut to the coordinate width
  assign x_ext  = fb_pkg::axi_addr_width'(s_gfx.x);
  assign y_ext  = fb_pkg::axi_addr_width'(s_gfx.y);
  assign hv_ext = fb_pkg::axi_addr_width'(h_visible);

  assign pix_index = y_ext * hv_ext + x_ext;  // row major pixel index

  always_comb begin
    next_wr      = '0;
    next_wr.addr = pix_index;
    next_wr.data = fb_pkg::axi_data_width'(s_gfx.pixel);  // upper bits stay zero
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_valid <= 1'b0;
    end else if (accept && in_range) begin
      wr_valid <= 1'b1;
    end else if (wr_ready) begin
      wr_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept && in_range) begin
      wr <= next_wr;
    end
  end

  // pixels outside the visible area are taken from the source and forgotten
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      clipped <= '0;
    end else if (accept && !in_range) begin
      clipped <= clipped + 16'd1;
    end
  end

endmodule

//--- fb_pkg.sv
package fb_pkg;

  // pixel coordinate and visible size widths
  localparam int h_width = 12;
  localparam int v_width = 12;

  localparam int pixel_width = 12;  // 4 bits per colour channel

  localparam int axi_addr_width = 20;
  localparam int axi_data_width = 16;
  localparam int axi_id_width   = 4;

  localparam logic [1:0] axi_resp_okay = 2'b00;

  // one pixel write request as it arrives on the gfx port
  typedef struct packed {
    logic [h_width-1:0]     x;
    logic [v_width-1:0]     y;
    logic [pixel_width-1:0] pixel;
  } fb_pixel_t;

  // a clipped pixel turned into a bus write, address in pixel units
  typedef struct packed {
    logic [axi_addr_width-1:0] addr;
    logic [axi_data_width-1:0] data;
  } fb_write_t;

  // running counts reported at the top level
  typedef struct packed {
    logic [15:0] writes_done;
    logic [15:0] clipped;
    logic [7:0]  resp_errors;
  } fb_status_t;

endpackage
